// File: exc_cases.txt
# name flags_1 pc_1 badvaddr_1 ds_1 flags_2 pc_2 badvaddr_2 ds_2 refetch hw_int raddr
#  exp_pc_ena exp_pc exp_flush, then next cycle exp_cp0_rdata exp_int_req, all hex
int_idle     00000 00000000 00000000 0 00000 00000000 00000000 0 0 00 0c 0 00000000 0 0040fc01 0
int_raise    00000 00000000 00000000 0 00000 00000000 00000000 0 0 01 0d 0 00000000 0 00000400 1
sys_slot2    00000 00000000 00000000 0 10002 80001000 00000000 0 0 01 0d 1 bfc00380 1 00000420 0
sys_epc      00000 00000000 00000000 0 00000 00000000 00000000 0 0 00 0e 0 00000000 0 80001000 0
refill_s_ds  12000 80002004 00400010 1 00000 00000000 00000000 0 0 00 0d 1 bfc00200 1 8000000c 0
refill_epc   00000 00000000 00000000 0 00000 00000000 00000000 0 0 00 0e 0 00000000 0 80002000 0
both_slots   10004 80003000 00000000 0 10002 80003004 00000000 0 0 00 0d 1 bfc00380 1 00000024 0
both_epc     00000 00000000 00000000 0 00000 00000000 00000000 0 0 00 0e 0 00000000 0 80003000 0
refetch_kill 10080 80004000 00000000 0 10002 80004004 00000000 0 1 00 0d 0 00000000 0 00000024 0
refetch_epc  00000 00000000 00000000 0 00000 00000000 00000000 0 0 00 0e 0 00000000 0 80003000 0
data_adel    10010 80005000 00401233 0 00000 00000000 00000000 0 0 00 08 1 bfc00380 1 00401233 0
adel_cause   00000 00000000 00000000 0 00000 00000000 00000000 0 0 00 0d 0 00000000 0 00000010 0
inst_adel    00000 00000000 00000000 0 10008 80006002 12345678 0 0 00 08 1 bfc00380 1 80006002 0
eret         10001 80007000 00000000 0 00000 00000000 00000000 0 0 00 0c 1 80006002 1 0040fc01 0
int_again    00000 00000000 00000000 0 00000 00000000 00000000 0 0 01 0d 0 00000000 0 00000410 1
int_exc      10100 80008000 00000000 0 00000 00000000 00000000 0 0 01 0c 1 bfc00380 1 0040fc03 0
int_cause    00000 00000000 00000000 0 00000 00000000 00000000 0 0 00 0d 0 00000000 0 00000000 0

// File: sim.f
exc_pkg.sv
cp0_pkg.sv
cp0_wr_if.sv
exception_ctrl.sv
cp0_regs.sv
exc_unit_top.sv
exc_checker.sv
exc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with verilator, run, then look for the fail message in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module exc_tb -o exc_sim \
    && ./obj_dir/exc_sim | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "Result: FAILED" sim.log && exit 1 || exit 0

// File: exc_tb.sv
module exc_tb
    import exc_pkg::*;
();
    localparam int POLL_STEP = 10;

    logic                  clk;
    logic                  rst_n;
    logic [31:0]           pc_1, badvaddr_1, pc_2, badvaddr_2;
    logic                  in_delay_slot_1, in_delay_slot_2;
    logic [EXC_FLAG_W-1:0] flags_1, flags_2;
    logic                  refetch;
    logic [5:0]            hw_int;
    logic [4:0]            cp0_raddr;
    logic                  exception_pc_ena, flush_pipeline, int_req;
    logic [31:0]           exception_pc, cp0_rdata;

    // expected values handed to the checker
    logic                  stim_chk, resp_chk;
    logic [127:0]          case_tag;
    logic                  exp_pc_ena, exp_flush, exp_int_req;
    logic [31:0]           exp_pc, exp_rdata;

    int                    check_count, error_count;
    int                    cycle_cnt = 0;
    logic                  timed_out;
    logic                  file_error;

    exc_unit_top u_dut (
        .clk(clk), .rst_n(rst_n),
        .pc_1(pc_1), .badvaddr_1(badvaddr_1), .in_delay_slot_1(in_delay_slot_1),
        .flags_1(flags_1),
        .pc_2(pc_2), .badvaddr_2(badvaddr_2), .in_delay_slot_2(in_delay_slot_2),
        .flags_2(flags_2),
        .refetch(refetch), .hw_int(hw_int), .cp0_raddr(cp0_raddr),
        .exception_pc_ena(exception_pc_ena), .exception_pc(exception_pc),
        .flush_pipeline(flush_pipeline), .int_req(int_req), .cp0_rdata(cp0_rdata)
    );

    exc_checker u_chk (
        .clk(clk), .rst_n(rst_n), .stim_chk(stim_chk), .resp_chk(resp_chk),
        .case_tag(case_tag), .exp_pc_ena(exp_pc_ena), .exp_pc(exp_pc),
        .exp_flush(exp_flush), .exp_rdata(exp_rdata), .exp_int_req(exp_int_req),
        .raddr(cp0_raddr), .exception_pc_ena(exception_pc_ena),
        .exception_pc(exception_pc), .flush_pipeline(flush_pipeline),
        .cp0_rdata(cp0_rdata), .int_req(int_req),
        .check_count(check_count), .error_count(error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // polls at posedge + 5 phase, gives up if the clock stalls
    task automatic wait_cycles(input int n);
        int target;
        int polls;
        target = cycle_cnt + n;
        polls  = 0;
        while (cycle_cnt < target && polls < n * 10 + 20) begin
            #POLL_STEP;
            polls++;
        end
        if (cycle_cnt < target) begin
            timed_out = 1'b1;
            $display("timeout: clock stopped after %0d cycles", cycle_cnt);
        end
    endtask

    task automatic idle_slots();
        flags_1         = '0;
        flags_2         = '0;
        pc_1            = $urandom();
        pc_2            = $urandom();
        badvaddr_1      = '0;
        badvaddr_2      = '0;
        in_delay_slot_1 = 1'b0;
        in_delay_slot_2 = 1'b0;
        refetch         = 1'b0;
    endtask

    // ******************************************************************
    // case loop
    // ******************************************************************
    initial begin
        int                    fd;
        int                    n_fields;
        int                    n_cases;
        string                 line;
        logic [127:0]          c_name;
        logic [EXC_FLAG_W-1:0] c_flags_1, c_flags_2;
        logic [31:0]           c_pc_1, c_bva_1, c_pc_2, c_bva_2, c_pc, c_rdata;
        logic                  c_ds_1, c_ds_2, c_refetch, c_ena, c_flush, c_int;
        logic [5:0]            c_hw_int;
        logic [4:0]            c_raddr;

        void'($urandom(87182));
        n_cases = 0;
        rst_n = 1'b0;
        hw_int = '0;
        cp0_raddr = '0;
        stim_chk = 1'b0;
        resp_chk = 1'b0;
        case_tag = '0;
        exp_pc_ena = 1'b0;
        exp_pc = '0;
        exp_flush = 1'b0;
        exp_rdata = '0;
        exp_int_req = 1'b0;
        timed_out = 1'b0;
        file_error = 1'b0;
        idle_slots();

        #5;
        wait_cycles(10);
        rst_n = 1'b1;

        fd = $fopen("exc_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open exc_cases.txt");
            file_error = 1'b1;
        end
        while (fd != 0 && !timed_out && !file_error && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n_fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               c_name, c_flags_1, c_pc_1, c_bva_1, c_ds_1,
                               c_flags_2, c_pc_2, c_bva_2, c_ds_2, c_refetch, c_hw_int,
                               c_raddr, c_ena, c_pc, c_flush, c_rdata, c_int);
            if (n_fields != 17) begin
                $display("malformed line in exc_cases.txt: %0s", line);
                file_error = 1'b1;
            end else begin
                wait_cycles(1);
                flags_1         = c_flags_1;
                pc_1            = (c_flags_1 == '0) ? $urandom() : c_pc_1;
                badvaddr_1      = c_bva_1;
                in_delay_slot_1 = c_ds_1;
                flags_2         = c_flags_2;
                pc_2            = (c_flags_2 == '0) ? $urandom() : c_pc_2;
                badvaddr_2      = c_bva_2;
                in_delay_slot_2 = c_ds_2;
                refetch         = c_refetch;
                hw_int          = c_hw_int;
                cp0_raddr       = c_raddr;
                case_tag        = c_name;
                exp_pc_ena      = c_ena;
                exp_pc          = c_pc;
                exp_flush       = c_flush;
                exp_rdata       = c_rdata;
                exp_int_req     = c_int;
                stim_chk        = 1'b1;
                resp_chk        = 1'b0;
                wait_cycles(1);
                idle_slots();          // hw_int and raddr held for the readback
                stim_chk = 1'b0;
                resp_chk = 1'b1;
                n_cases++;
            end
        end
        wait_cycles(1);
        resp_chk = 1'b0;
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("cases run: %0d, checks: %0d, errors: %0d", n_cases, check_count, error_count);
        if (timed_out || file_error || n_cases == 0 || error_count != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

// File: exc_checker.sv
module exc_checker
    import cp0_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         stim_chk,      // redirect outputs are checked this cycle
    input  logic         resp_chk,      // cp0 state is checked this cycle
    input  logic [127:0] case_tag,
    input  logic         exp_pc_ena,
    input  logic [31:0]  exp_pc,
    input  logic         exp_flush,
    input  logic [31:0]  exp_rdata,
    input  logic         exp_int_req,

    // dut side
    input  logic [4:0]   raddr,
    input  logic         exception_pc_ena,
    input  logic [31:0]  exception_pc,
    input  logic         flush_pipeline,
    input  logic [31:0]  cp0_rdata,
    input  logic         int_req,

    output int           check_count,
    output int           error_count
);
    cp0_word_u exp_word;
    cp0_word_u act_word;

    task automatic compare(input string sig, input logic [31:0] exp_v, input logic [31:0] act_v);
        check_count++;
        if (exp_v !== act_v) begin
            error_count++;
            $display("[ERROR] %0s %0s: expected %h, actual %h", case_tag, sig, exp_v, act_v);
        end
    endtask

    // field breakdown of a wrong cause or status word, expected/actual
    task automatic show_fields();
        exp_word.raw = exp_rdata;
        act_word.raw = cp0_rdata;
        if (raddr == CP0_CAUSE) begin
            $display("        cause bd %0b/%0b ip %h/%h exccode %0d/%0d",
                     exp_word.cause.bd, act_word.cause.bd,
                     exp_word.cause.ip, act_word.cause.ip,
                     exp_word.cause.exccode, act_word.cause.exccode);
        end else if (raddr == CP0_STATUS) begin
            $display("        status im %h/%h exl %0b/%0b ie %0b/%0b",
                     exp_word.status.im, act_word.status.im,
                     exp_word.status.exl, act_word.status.exl,
                     exp_word.status.ie, act_word.status.ie);
        end
    endtask

    // ******************************************************************
    // sample at the falling edge, inputs settled since posedge + 5
    // ******************************************************************
    always @(negedge clk) begin
        if (!rst_n) begin
            check_count = 0;
            error_count = 0;
        end else begin
            if (stim_chk) begin
                compare("exception_pc_ena", {31'b0, exp_pc_ena}, {31'b0, exception_pc_ena});
                if (exp_pc_ena) begin
                    compare("exception_pc", exp_pc, exception_pc);  // only meaningful on a redirect
                end
                compare("flush_pipeline", {31'b0, exp_flush}, {31'b0, flush_pipeline});
            end
            if (resp_chk) begin
                compare("cp0_rdata", exp_rdata, cp0_rdata);
                if (exp_rdata !== cp0_rdata) begin
                    show_fields();
                end
                compare("int_req", {31'b0, exp_int_req}, {31'b0, int_req});
            end
        end
    end

endmodule

// File: exc_unit_top.sv
module exc_unit_top
    import exc_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // retiring slot 1, older
    input  logic [31:0]           pc_1,
    input  logic [31:0]           badvaddr_1,
    input  logic                  in_delay_slot_1,
    input  logic [EXC_FLAG_W-1:0] flags_1,

    // retiring slot 2
    input  logic [31:0]           pc_2,
    input  logic [31:0]           badvaddr_2,
    input  logic                  in_delay_slot_2,
    input  logic [EXC_FLAG_W-1:0] flags_2,

    input  logic                  refetch,
    input  logic [5:0]            hw_int,
    input  logic [4:0]            cp0_raddr,

    output logic                  exception_pc_ena,
    output logic [31:0]           exception_pc,
    output logic                  flush_pipeline,
    output logic                  int_req,
    output logic [31:0]           cp0_rdata
);
    cp0_wr_if cp0_bus (.clk(clk));

    exception_ctrl u_ctrl (
        .pc_1             (pc_1),
        .pc_2             (pc_2),
        .badvaddr_1       (badvaddr_1),
        .badvaddr_2       (badvaddr_2),
        .in_delay_slot_1  (in_delay_slot_1),
        .in_delay_slot_2  (in_delay_slot_2),
        .flags_1          (flags_1),
        .flags_2          (flags_2),
        .refetch          (refetch),
        .exception_pc_ena (exception_pc_ena),
        .exception_pc     (exception_pc),
        .flush_pipeline   (flush_pipeline),
        .cp0              (cp0_bus.ctrl)
    );

    cp0_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .cp0     (cp0_bus.regs),
        .hw_int  (hw_int),
        .raddr   (cp0_raddr),
        .rdata   (cp0_rdata),
        .int_req (int_req)
    );

endmodule

// File: cp0_regs.sv
module cp0_regs
    import cp0_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    cp0_wr_if.regs      cp0,

    input  logic [5:0]  hw_int,
    input  logic [4:0]  raddr,
    output logic [31:0] rdata,
    output logic        int_req
);
    cp0_word_u   status_q;
    cp0_word_u   cause_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;

    // ******************************************************************
    // register update
    // ******************************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q.raw <= STATUS_RESET;
            cause_q.raw  <= '0;
            epc_q        <= '0;
            badvaddr_q   <= '0;
        end else begin
            cause_q.cause.ip[7:2] <= hw_int;   // sampled every cycle
            if (cp0.update_ena) begin
                cause_q.cause.exccode <= cp0.exccode;
                cause_q.cause.bd      <= cp0.bd;
                status_q.status.exl   <= cp0.exl_set;
                epc_q                 <= cp0.epc;
                if (cp0.badvaddr_ena) begin
                    badvaddr_q <= cp0.badvaddr;
                end
            end else if (cp0.cls_exl) begin
                status_q.status.exl <= 1'b0;
            end
        end
    end

    assign cp0.r_epc = epc_q;
    assign cp0.exl   = status_q.status.exl;

    // unmasked pending line while outside exception level
    assign int_req = status_q.status.ie
                   & ~status_q.status.exl
                   & (|(cause_q.cause.ip & status_q.status.im));

    // ******************************************************************
    // read port
    // ******************************************************************
    always_comb begin
        case (raddr)
            CP0_STATUS:   rdata = status_q.raw;
            CP0_CAUSE:    rdata = cause_q.raw;
            CP0_EPC:      rdata = epc_q;
            CP0_BADVADDR: rdata = badvaddr_q;
            default:      rdata = 32'h0;
        endcase
    end

    // exception taken by the controller is visible as EXL next cycle
    a_exl_after_update: assert property (
        @(posedge clk) disable iff (!rst_n)
        cp0.update_ena |=> cp0.exl
    );

endmodule

// File: exception_ctrl.sv
module exception_ctrl
    import exc_pkg::*;
(
    input  logic [31:0]           pc_1,
    input  logic [31:0]           pc_2,
    input  logic [31:0]           badvaddr_1,
    input  logic [31:0]           badvaddr_2,
    input  logic                  in_delay_slot_1,
    input  logic                  in_delay_slot_2,
    input  logic [EXC_FLAG_W-1:0] flags_1,
    input  logic [EXC_FLAG_W-1:0] flags_2,
    input  logic                  refetch,

    output logic                  exception_pc_ena,
    output logic [31:0]           exception_pc,
    output logic                  flush_pipeline,

    cp0_wr_if.ctrl                cp0
);
    logic                  take_1;
    logic                  take_2;
    logic                  take;
    logic [EXC_FLAG_W-1:0] sel_flags;
    logic [31:0]           sel_pc;
    logic [31:0]           sel_badvaddr;
    logic                  sel_ds;

    // refetch kills everything this cycle
    assign take_1 = flags_1[FLG_HAS] & ~refetch;
    assign take_2 = flags_2[FLG_HAS] & ~refetch;
    assign take   = take_1 | take_2;

    assign exception_pc_ena = take;
    assign flush_pipeline   = take;

    // slot 1 is the older instruction and wins
    assign sel_flags    = take_1 ? flags_1 : flags_2;
    assign sel_pc       = take_1 ? pc_1 : pc_2;
    assign sel_badvaddr = take_1 ? badvaddr_1 : badvaddr_2;
    assign sel_ds       = take_1 ? in_delay_slot_1 : in_delay_slot_2;

    // ******************************************************************
    // priority decode of the chosen slot
    // ******************************************************************
    always_comb begin
        exception_pc     = VEC_GENERAL;
        cp0.update_ena   = 1'b0;
        cp0.exccode      = EXC_INT;
        cp0.bd           = 1'b0;
        cp0.exl_set      = 1'b0;
        cp0.epc          = 32'h0;
        cp0.badvaddr_ena = 1'b0;
        cp0.badvaddr     = 32'h0;
        cp0.cls_exl      = 1'b0;
        if (take) begin
            cp0.update_ena = 1'b1;
            cp0.exl_set    = 1'b1;
            cp0.bd         = sel_ds;
            cp0.epc        = sel_ds ? sel_pc - 32'd4 : sel_pc;  // back up to the branch
            if (take_1 && sel_flags[FLG_INT]) begin
                cp0.exccode = EXC_INT;
            end else if (!take_1 && sel_flags[FLG_INST_ADEL]) begin
                // slot 2 checks its fetch address first
                cp0.exccode      = EXC_ADEL;
                cp0.badvaddr_ena = 1'b1;
                cp0.badvaddr     = sel_pc;
            end else if (sel_flags[FLG_I_REFILL_L]) begin
                cp0.exccode  = EXC_TLBL;
                exception_pc = VEC_REFILL;
            end else if (sel_flags[FLG_I_INVALID_L]) begin
                cp0.exccode = EXC_TLBL;
            end else if (sel_flags[FLG_INST_ADEL]) begin
                cp0.exccode      = EXC_ADEL;
                cp0.badvaddr_ena = 1'b1;
                cp0.badvaddr     = sel_pc;     // fetch address is the pc
            end else if (sel_flags[FLG_RI]) begin
                cp0.exccode = EXC_RI;
            end else if (sel_flags[FLG_OVERFLOW]) begin
                cp0.exccode = EXC_OV;
            end else if (sel_flags[FLG_SYSCALL]) begin
                cp0.exccode = EXC_SYS;
            end else if (sel_flags[FLG_BREAK]) begin
                cp0.exccode = EXC_BP;
            end else if (sel_flags[FLG_ERET]) begin
                cp0.update_ena = 1'b0;         // eret only drops EXL
                cp0.cls_exl    = 1'b1;
                exception_pc   = cp0.r_epc;
            end else if (sel_flags[FLG_D_REFILL_L]) begin
                cp0.exccode  = EXC_TLBL;
                exception_pc = VEC_REFILL;
            end else if (sel_flags[FLG_D_INVALID_L]) begin
                cp0.exccode = EXC_TLBL;
            end else if (sel_flags[FLG_D_REFILL_S]) begin
                cp0.exccode  = EXC_TLBS;
                exception_pc = VEC_REFILL;
            end else if (sel_flags[FLG_D_INVALID_S]) begin
                cp0.exccode = EXC_TLBS;
            end else if (sel_flags[FLG_DATA_ADEL]) begin
                cp0.exccode      = EXC_ADEL;
                cp0.badvaddr_ena = 1'b1;
                cp0.badvaddr     = sel_badvaddr;
            end else if (sel_flags[FLG_DATA_ADES]) begin
                cp0.exccode      = EXC_ADES;
                cp0.badvaddr_ena = 1'b1;
                cp0.badvaddr     = sel_badvaddr;
            end else if (sel_flags[FLG_MOD]) begin
                cp0.exccode = EXC_MOD;
            end
        end
    end

    // the register block applies either an update or an eret, never both
    a_update_xor_eret: assert property (
        @(posedge cp0.clk) !(cp0.update_ena && cp0.cls_exl)
    );

endmodule

// File: cp0_wr_if.sv
interface cp0_wr_if (
    input logic clk
);
    logic        update_ena;    // take an exception this cycle
    logic [4:0]  exccode;
    logic        bd;
    logic        exl_set;
    logic [31:0] epc;
    logic        badvaddr_ena;
    logic [31:0] badvaddr;
    logic        cls_exl;       // eret
    // state returned by the register block
    logic [31:0] r_epc;
    logic        exl;

    modport ctrl (
        input  clk, r_epc, exl,
        output update_ena, exccode, bd, exl_set, epc,
        output badvaddr_ena, badvaddr, cls_exl
    );

    modport regs (
        input  update_ena, exccode, bd, exl_set, epc,
        input  badvaddr_ena, badvaddr, cls_exl,
        output r_epc, exl
    );
endinterface

// File: cp0_pkg.sv
package cp0_pkg;

    // ******************************************************************
    // register numbers on the read port
    // ******************************************************************
    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    // BEV=1, IM[7:2]=all ones, IE=1
    localparam logic [31:0] STATUS_RESET = 32'h0040_fc01;

    // ******************************************************************
    // Cause / Status word
    // ******************************************************************
    // raw is what the read port returns, the other two views are
    // used by the register block to touch single fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic        bd;        // 31
            logic [14:0] rsv_hi;    // 30:16
            logic [7:0]  ip;        // 15:8, [7:2] hardware lines
            logic        rsv_7;
            logic [4:0]  exccode;   // 6:2
            logic [1:0]  rsv_lo;
        } cause;
        struct packed {
            logic [8:0]  rsv_hi;    // 31:23
            logic        bev;       // 22
            logic [5:0]  rsv_mid;   // 21:16
            logic [7:0]  im;        // 15:8
            logic [5:0]  rsv_lo;    // 7:2
            logic        exl;
            logic        ie;
        } status;
    } cp0_word_u;

endpackage

// File: exc_pkg.sv
package exc_pkg;

    // ******************************************************************
    // per-slot exception flags
    // ******************************************************************
    localparam int unsigned EXC_FLAG_W = 17;

    localparam int unsigned FLG_ERET        = 0;
    localparam int unsigned FLG_SYSCALL     = 1;
    localparam int unsigned FLG_BREAK       = 2;
    localparam int unsigned FLG_INST_ADEL   = 3;
    localparam int unsigned FLG_DATA_ADEL   = 4;
    localparam int unsigned FLG_DATA_ADES   = 5;
    localparam int unsigned FLG_OVERFLOW    = 6;
    localparam int unsigned FLG_RI          = 7;
    localparam int unsigned FLG_INT         = 8;
    localparam int unsigned FLG_I_REFILL_L  = 9;   // fetch tlb refill
    localparam int unsigned FLG_I_INVALID_L = 10;
    localparam int unsigned FLG_D_REFILL_L  = 11;  // load tlb refill
    localparam int unsigned FLG_D_INVALID_L = 12;
    localparam int unsigned FLG_D_REFILL_S  = 13;  // store tlb refill
    localparam int unsigned FLG_D_INVALID_S = 14;
    localparam int unsigned FLG_MOD         = 15;
    localparam int unsigned FLG_HAS         = 16;  // slot carries any exception

    // ******************************************************************
    // Cause.ExcCode values
    // ******************************************************************
    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_MOD  = 5'd1;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;

    // boot vectors, BEV=1
    localparam logic [31:0] VEC_GENERAL = 32'hbfc0_0380;
    localparam logic [31:0] VEC_REFILL  = 32'hbfc0_0200;

endpackage
